//--- src/sdhc_pkg.sv
package sdhc_pkg;

  // Field widths of the block register
  localparam int block_count_w = 16;
  localparam int block_size_w  = 12;

  // Host register word addresses
  typedef logic [1:0] reg_addr_t;

  localparam reg_addr_t addr_block     = 2'd0;
  localparam reg_addr_t addr_xfer_mode = 2'd1;
  localparam reg_addr_t addr_data_port = 2'd2;
  localparam reg_addr_t addr_status    = 2'd3;

  // Bit positions in the transfer mode and status words
  localparam int xfer_multi_bit   = 0;
  localparam int status_rd_en_bit = 0;
  localparam int status_wr_en_bit = 1;
  localparam int status_empty_bit = 2;

  typedef struct packed {
    logic [block_count_w-1:0] block_count;
    logic [3:0]               reserved;
    logic [block_size_w-1:0]  block_size;
  } blk_fields_t;

  // One register word, seen as raw bits, a data port word or the block fields
  typedef union packed {
    logic [31:0] raw;
    logic [31:0] port_word;
    blk_fields_t blk;
  } reg_word_u;

endpackage

//--- src/buf_reg_if.sv
`timescale 1ns/100ps

interface buf_reg_if
  import sdhc_pkg::*;
();

  logic [block_size_w-1:0]  block_size;
  logic [block_count_w-1:0] block_count;
  logic                     multi_block;

  logic [31:0] port_wdata;
  logic        port_we;
  logic        port_re;
  logic [31:0] port_rdata;      // FIFO front word for data port reads

  logic read_enable;
  logic write_enable;
  logic empty;

  logic                     count_de;  // Block count update strobe
  logic [block_count_w-1:0] count_d;

  modport regs_mp (
    output block_size, block_count, multi_block,
    output port_wdata, port_we, port_re,
    input  port_rdata, read_enable, write_enable, empty,
    input  count_de, count_d
  );

  modport buf_mp (
    input  block_size, block_count, multi_block,
    input  port_wdata, port_we, port_re,
    output port_rdata, read_enable, write_enable, empty,
    output count_de, count_d
  );

endinterface

//--- src/word_fifo.sv
`timescale 1ns/100ps

module word_fifo #(
  parameter int unsigned num_words = 16
) (
  input  logic clk_i,
  input  logic rst_n_i,

  input  logic en_i,

  input  logic        push_i,
  input  logic [31:0] push_data_i,
  input  logic        pop_i,

  output logic [31:0] front_data_o,
  output logic        full_o,
  output logic        empty_o,
  output logic [$clog2(num_words + 1)-1:0] length_o
);

  localparam int ptr_w = (num_words > 1) ? $clog2(num_words) : 1;
  localparam int len_w = $clog2(num_words + 1);

  logic [31:0] mem [num_words];

  logic [ptr_w-1:0] head_q, tail_q;
  logic [len_w-1:0] count_q;
  logic             do_push, do_pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(num_words - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o   = (count_q == len_w'(num_words));
  assign empty_o  = (count_q == '0);
  assign length_o = count_q;

  // Full and empty guard the pointers, en_i gates everything
  assign do_push = en_i && push_i && !full_o;
  assign do_pop  = en_i && pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        tail_q <= next_ptr(tail_q);
      end
      if (do_pop) begin
        head_q <= next_ptr(head_q);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[tail_q] <= push_data_i;
    end
  end

  assign front_data_o = mem[head_q];  // New front is visible the cycle after a pop

endmodule

//--- src/dat_buffer.sv
`timescale 1ns/100ps

module dat_buffer
  import sdhc_pkg::*;
#(
  parameter int unsigned num_words      = 16,
  parameter int unsigned max_block_bits = 12
) (
  input  logic clk_i,
  input  logic rst_n_i,

  input  logic read_op_i,
  input  logic write_op_i,

  // Card side fills the buffer in a read operation
  input  logic        card_wvalid_i,
  input  logic [31:0] card_wdata_i,
  output logic        card_wready_o,

  // Card side drains the buffer in a write operation
  output logic        card_rvalid_o,
  output logic [31:0] card_rdata_o,
  input  logic        card_rready_i,

  buf_reg_if.buf_mp regs
);

  localparam int num_bytes = num_words * 4;
  localparam int len_w     = $clog2(num_words + 1);
  localparam int byte_w    = len_w + 2;
  localparam int cmp_w     = (byte_w > max_block_bits) ? byte_w : max_block_bits;

  logic        fifo_en, fifo_push, fifo_pop;
  logic [31:0] fifo_push_data, fifo_front;
  logic        fifo_full, fifo_empty;
  logic [len_w-1:0] fifo_length;

  logic rd_dir, wr_dir;

  logic [byte_w-1:0] used_bytes, free_bytes;
  logic              has_block, has_space;

  logic [max_block_bits-1:0] block_size;
  logic [max_block_bits-1:0] blk_words;
  logic [max_block_bits-1:0] word_cnt_q, word_cnt_d;

  logic                     port_strobe, block_done, count_update, enable_gap;
  logic [block_count_w-1:0] count_next;

  // Read operation wins if both levels are high
  assign rd_dir  = read_op_i;
  assign wr_dir  = write_op_i && !read_op_i;
  assign fifo_en = read_op_i || write_op_i;

  assign block_size = max_block_bits'(regs.block_size);

  assign used_bytes = {fifo_length, 2'b00};
  assign free_bytes = byte_w'(num_bytes) - used_bytes;

  assign has_block = cmp_w'(used_bytes) >= cmp_w'(block_size);
  assign has_space = cmp_w'(free_bytes) >= cmp_w'(block_size);

  // Steering by direction
  always_comb begin
    fifo_push       = 1'b0;
    fifo_push_data  = '0;
    fifo_pop        = 1'b0;
    card_wready_o   = 1'b0;
    card_rvalid_o   = 1'b0;
    card_rdata_o    = '0;
    regs.port_rdata = '0;

    if (rd_dir) begin
      card_wready_o   = has_space && !fifo_full;
      fifo_push       = card_wvalid_i && card_wready_o;
      fifo_push_data  = card_wdata_i;
      fifo_pop        = regs.port_re;
      regs.port_rdata = fifo_front;
    end else if (wr_dir) begin
      card_rvalid_o  = has_block && !fifo_empty;
      card_rdata_o   = fifo_front;
      fifo_pop       = card_rready_i && card_rvalid_o;
      fifo_push      = regs.port_we;
      fifo_push_data = regs.port_wdata;
    end
  end

  // Words per block, rounded up
  assign blk_words = max_block_bits'(block_size >> 2) + max_block_bits'(|block_size[1:0]);

  assign port_strobe = (rd_dir && regs.port_re) || (wr_dir && regs.port_we);
  assign block_done  = port_strobe && (word_cnt_q == blk_words - 1'b1);

  always_comb begin
    word_cnt_d = word_cnt_q;
    if (block_done) begin
      word_cnt_d = '0;
    end else if (port_strobe) begin
      word_cnt_d = word_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      word_cnt_q <= '0;
    end else begin
      word_cnt_q <= word_cnt_d;
    end
  end

  assign count_next   = regs.block_count - block_count_w'(1);
  assign count_update = block_done && regs.multi_block;
  // One-cycle dip in the enables between blocks, not after the last one
  assign enable_gap   = count_update && (regs.block_count != block_count_w'(1));

  assign regs.count_de     = count_update;
  assign regs.count_d      = count_next;
  assign regs.read_enable  = rd_dir && has_block && !enable_gap;
  assign regs.write_enable = wr_dir && has_space && !enable_gap;
  assign regs.empty        = fifo_empty;

  word_fifo #(
    .num_words (num_words)
  ) word_fifo_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .en_i         (fifo_en),
    .push_i       (fifo_push),
    .push_data_i  (fifo_push_data),
    .pop_i        (fifo_pop),
    .front_data_o (fifo_front),
    .full_o       (fifo_full),
    .empty_o      (fifo_empty),
    .length_o     (fifo_length)
  );

endmodule

//--- src/buffer_regs.sv
`timescale 1ns/100ps

module buffer_regs
  import sdhc_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,

  input  reg_addr_t   reg_addr_i,
  input  logic        reg_we_i,
  input  logic        reg_re_i,
  input  logic [31:0] reg_wdata_i,
  output logic [31:0] reg_rdata_o,

  buf_reg_if.regs_mp regs
);

  logic [block_size_w-1:0]  block_size_q;
  logic [block_count_w-1:0] block_count_q;
  logic                     multi_block_q;

  reg_word_u wr_word;
  reg_word_u rd_word;

  logic blk_we, mode_we;

  assign wr_word.raw = reg_wdata_i;

  assign blk_we  = reg_we_i && (reg_addr_i == addr_block);
  assign mode_we = reg_we_i && (reg_addr_i == addr_xfer_mode);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      block_size_q  <= '0;
      block_count_q <= '0;
      multi_block_q <= 1'b0;
    end else begin
      if (blk_we) begin
        block_size_q <= wr_word.blk.block_size;
      end
      if (regs.count_de) begin
        block_count_q <= regs.count_d;  // Buffer update beats a host write
      end else if (blk_we) begin
        block_count_q <= wr_word.blk.block_count;
      end
      if (mode_we) begin
        multi_block_q <= wr_word.raw[xfer_multi_bit];
      end
    end
  end

  assign regs.block_size  = block_size_q;
  assign regs.block_count = block_count_q;
  assign regs.multi_block = multi_block_q;

  // Data port strobes go straight to the buffer
  assign regs.port_wdata = wr_word.port_word;
  assign regs.port_we    = reg_we_i && (reg_addr_i == addr_data_port);
  assign regs.port_re    = reg_re_i && (reg_addr_i == addr_data_port);

  always_comb begin
    rd_word.raw = '0;
    case (reg_addr_i)
      addr_block: begin
        rd_word.blk.block_count = block_count_q;
        rd_word.blk.block_size  = block_size_q;
      end
      addr_xfer_mode: begin
        rd_word.raw[xfer_multi_bit] = multi_block_q;
      end
      addr_data_port: begin
        rd_word.port_word = regs.port_rdata;
      end
      addr_status: begin
        rd_word.raw[status_rd_en_bit] = regs.read_enable;
        rd_word.raw[status_wr_en_bit] = regs.write_enable;
        rd_word.raw[status_empty_bit] = regs.empty;
      end
      default: begin
        rd_word.raw = '0;
      end
    endcase
  end

  // Captured on the same edge that pops the data port word
  always_ff @(posedge clk_i) begin
    if (reg_re_i) begin
      reg_rdata_o <= rd_word.raw;
    end
  end

endmodule

//--- src/sdhc_buffer_top.sv
`timescale 1ns/100ps

module sdhc_buffer_top
  import sdhc_pkg::*;
#(
  parameter int unsigned num_words      = 16,
  parameter int unsigned max_block_bits = 12
) (
  input  logic clk_i,
  input  logic rst_n_i,

  // Operation levels from the command side
  input  logic read_op_i,
  input  logic write_op_i,

  input  reg_addr_t   reg_addr_i,
  input  logic        reg_we_i,
  input  logic        reg_re_i,
  input  logic [31:0] reg_wdata_i,
  output logic [31:0] reg_rdata_o,

  input  logic        card_wvalid_i,
  input  logic [31:0] card_wdata_i,
  output logic        card_wready_o,

  output logic        card_rvalid_o,
  output logic [31:0] card_rdata_o,
  input  logic        card_rready_i
);

  buf_reg_if buf_reg_if_i ();

  buffer_regs buffer_regs_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_addr_i  (reg_addr_i),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .regs        (buf_reg_if_i.regs_mp)
  );

  dat_buffer #(
    .num_words      (num_words),
    .max_block_bits (max_block_bits)
  ) dat_buffer_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .read_op_i     (read_op_i),
    .write_op_i    (write_op_i),
    .card_wvalid_i (card_wvalid_i),
    .card_wdata_i  (card_wdata_i),
    .card_wready_o (card_wready_o),
    .card_rvalid_o (card_rvalid_o),
    .card_rdata_o  (card_rdata_o),
    .card_rready_i (card_rready_i),
    .regs          (buf_reg_if_i.buf_mp)
  );

endmodule

//--- bench/sdhc_buffer_tb.sv
`timescale 1ns/100ps

module sdhc_buffer_tb
  import sdhc_pkg::*;
();

  localparam int clk_period   = 40;
  localparam int reset_cycles = 8;

  typedef enum logic [2:0] {
    st_set_op,     // data bit 0 read op, bit 1 write op
    st_reg_wr,     // Data port writes send the next LFSR word
    st_reg_rd,     // Data port reads expect the model front
    st_card_push,
    st_card_pop,
    st_levels      // exp bit 1 card_rvalid_o, bit 0 card_wready_o
  } step_kind_t;

  typedef struct packed {
    step_kind_t  kind;
    reg_addr_t   addr;
    logic [31:0] data;
    logic [31:0] exp;
  } step_t;

  logic        clk;
  logic        rst_n;
  logic        read_op;
  logic        write_op;
  reg_addr_t   reg_addr;
  logic        reg_we;
  logic        reg_re;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic        card_wvalid;
  logic [31:0] card_wdata;
  logic        card_wready;
  logic        card_rvalid;
  logic [31:0] card_rdata;
  logic        card_rready;

  step_t       steps[$];
  logic [31:0] model_q[$];   // Expected FIFO order
  logic [31:0] lfsr_q;
  int          errors      = 0;
  int          checks      = 0;
  int          cycles      = 0;
  int          cycle_limit = 0;

  sdhc_buffer_top #(
    .num_words      (16),
    .max_block_bits (12)
  ) sdhc_buffer_top_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .read_op_i     (read_op),
    .write_op_i    (write_op),
    .reg_addr_i    (reg_addr),
    .reg_we_i      (reg_we),
    .reg_re_i      (reg_re),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (reg_rdata),
    .card_wvalid_i (card_wvalid),
    .card_wdata_i  (card_wdata),
    .card_wready_o (card_wready),
    .card_rvalid_o (card_rvalid),
    .card_rdata_o  (card_rdata),
    .card_rready_i (card_rready)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the step table did not complete", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic draw_word(output logic [31:0] word);
    word = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      word   = {word[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic take_expected(output logic [31:0] word);
    if (model_q.size() == 0) begin
      errors++;
      $display("A data word was read while the model holds no words");
      word = '0;
    end else begin
      word = model_q.pop_front();
    end
  endtask

  function automatic void add_step(input step_kind_t kind, input reg_addr_t addr,
                                   input logic [31:0] data, input logic [31:0] exp);
    step_t s;
    s.kind = kind;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    steps.push_back(s);
  endfunction

  function automatic void build_table();
    // Idle after reset
    add_step(st_reg_rd, addr_status, 32'h0, 32'h4);
    add_step(st_levels, addr_block, 32'h0, 32'h0);
    // Write operation, 8 byte blocks, two blocks, multi-block
    add_step(st_reg_wr, addr_block, 32'h0002_0008, 32'h0);
    add_step(st_reg_wr, addr_xfer_mode, 32'h1, 32'h0);
    add_step(st_set_op, addr_block, 32'h2, 32'h0);
    add_step(st_reg_rd, addr_status, 32'h0, 32'h6);
    add_step(st_reg_rd, addr_block, 32'h0, 32'h0002_0008);
    add_step(st_reg_wr, addr_data_port, 32'h0, 32'h0);
    add_step(st_levels, addr_block, 32'h0, 32'h0);   // Half a block only
    add_step(st_reg_wr, addr_data_port, 32'h0, 32'h0);
    add_step(st_levels, addr_block, 32'h0, 32'h2);
    add_step(st_reg_rd, addr_block, 32'h0, 32'h0001_0008);
    add_step(st_card_pop, addr_block, 32'h0, 32'h0);
    add_step(st_reg_wr, addr_data_port, 32'h0, 32'h0);
    add_step(st_reg_wr, addr_data_port, 32'h0, 32'h0);
    add_step(st_reg_rd, addr_block, 32'h0, 32'h0000_0008);
    add_step(st_card_pop, addr_block, 32'h0, 32'h0);
    add_step(st_card_pop, addr_block, 32'h0, 32'h0);
    add_step(st_levels, addr_block, 32'h0, 32'h0);   // One word left over
    // Single-block mode keeps the count
    add_step(st_reg_wr, addr_xfer_mode, 32'h0, 32'h0);
    add_step(st_reg_wr, addr_block, 32'h0003_0008, 32'h0);
    add_step(st_reg_wr, addr_data_port, 32'h0, 32'h0);
    add_step(st_reg_wr, addr_data_port, 32'h0, 32'h0);
    add_step(st_reg_rd, addr_block, 32'h0, 32'h0003_0008);
    add_step(st_card_pop, addr_block, 32'h0, 32'h0);
    add_step(st_card_pop, addr_block, 32'h0, 32'h0);
    add_step(st_reg_rd, addr_status, 32'h0, 32'h2);
    // Read operation, 16 byte blocks
    add_step(st_set_op, addr_block, 32'h1, 32'h0);
    add_step(st_reg_wr, addr_block, 32'h0001_0010, 32'h0);
    add_step(st_reg_rd, addr_status, 32'h0, 32'h0);
    add_step(st_card_push, addr_block, 32'h0, 32'h0);
    add_step(st_card_push, addr_block, 32'h0, 32'h0);
    add_step(st_reg_rd, addr_status, 32'h0, 32'h0);
    add_step(st_card_push, addr_block, 32'h0, 32'h0);
    add_step(st_reg_rd, addr_status, 32'h0, 32'h1);
    repeat (4) begin
      add_step(st_reg_rd, addr_data_port, 32'h0, 32'h0);
    end
    add_step(st_reg_rd, addr_status, 32'h0, 32'h4);
    add_step(st_reg_rd, addr_block, 32'h0, 32'h0001_0010);
    // 48 byte block, space runs short after five words
    add_step(st_reg_wr, addr_block, 32'h0001_0030, 32'h0);
    repeat (5) begin
      add_step(st_card_push, addr_block, 32'h0, 32'h0);
    end
    add_step(st_levels, addr_block, 32'h0, 32'h0);
    add_step(st_reg_rd, addr_data_port, 32'h0, 32'h0);
    add_step(st_levels, addr_block, 32'h0, 32'h1);
    add_step(st_card_push, addr_block, 32'h0, 32'h0);
    add_step(st_levels, addr_block, 32'h0, 32'h0);
  endfunction

  task automatic apply_step(input step_t s);
    logic [31:0] word;
    logic [31:0] expect_word;
    word        = s.data;
    expect_word = s.exp;
    case (s.kind)
      st_set_op: begin
        @(posedge clk);
        read_op  <= s.data[0];
        write_op <= s.data[1];
      end
      st_reg_wr: begin
        if (s.addr == addr_data_port) begin
          draw_word(word);
          model_q.push_back(word);
        end
        @(posedge clk);
        reg_addr  <= s.addr;
        reg_wdata <= word;
        reg_we    <= 1'b1;
        @(posedge clk);
        reg_we <= 1'b0;
      end
      st_reg_rd: begin
        if (s.addr == addr_data_port) begin
          take_expected(expect_word);
        end
        @(posedge clk);
        reg_addr <= s.addr;
        reg_re   <= 1'b1;
        @(posedge clk);
        reg_re <= 1'b0;
        @(negedge clk);
        check_value("reg_rdata_o", reg_rdata, expect_word);
      end
      st_card_push: begin
        draw_word(word);
        model_q.push_back(word);
        @(posedge clk);
        card_wdata  <= word;
        card_wvalid <= 1'b1;
        @(negedge clk);
        while (!card_wready) begin
          @(negedge clk);
        end
        @(posedge clk);   // Accepted on this edge
        card_wvalid <= 1'b0;
      end
      st_card_pop: begin
        take_expected(expect_word);
        @(posedge clk);
        card_rready <= 1'b1;
        @(negedge clk);
        while (!card_rvalid) begin
          @(negedge clk);
        end
        check_value("card_rdata_o", card_rdata, expect_word);
        @(posedge clk);
        card_rready <= 1'b0;
      end
      st_levels: begin
        @(negedge clk);
        check_value("card_rvalid_o", {31'd0, card_rvalid}, {31'd0, s.exp[1]});
        check_value("card_wready_o", {31'd0, card_wready}, {31'd0, s.exp[0]});
      end
      default: begin
        errors++;
        $display("Step table holds an unknown step kind");
      end
    endcase
  endtask

  initial begin
    rst_n       <= 1'b0;
    read_op     <= 1'b0;
    write_op    <= 1'b0;
    reg_addr    <= addr_block;
    reg_we      <= 1'b0;
    reg_re      <= 1'b0;
    reg_wdata   <= '0;
    card_wvalid <= 1'b0;
    card_wdata  <= '0;
    card_rready <= 1'b0;
    lfsr_q = 32'd811;
    build_table();
    cycle_limit = steps.size() * 4 + 100;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    repeat (2) @(posedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- sim.f
src/sdhc_pkg.sv
src/buf_reg_if.sv
src/word_fifo.sv
src/dat_buffer.sv
src/buffer_regs.sv
src/sdhc_buffer_top.sv
bench/sdhc_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module sdhc_buffer_tb -f sim.f -o sim_bin &&
./obj_dir/sim_bin | tee /dev/stderr | grep -qx "all tests passed" &&
exit 0 || exit 1
